/* apu_cfg.svh */
`ifndef APU_CFG_SVH
`define APU_CFG_SVH

// Channel data path widths
`define APU_PERIOD_W 11
`define APU_DATA_W 8
`define APU_VOL_W 4

// Write port size
`define APU_NUM_REGS 4

// Periods below this silence the channel
`define APU_MIN_PERIOD 8

`endif

/* apu_pkg.sv */
`default_nettype none

`include "apu_cfg.svh"

package apu_pkg;

	// Write port
	typedef logic [`APU_DATA_W-1:0] reg_data_t;
	typedef logic [$clog2(`APU_NUM_REGS)-1:0] reg_addr_t;

	// Timer and output level
	typedef logic [`APU_PERIOD_W-1:0] period_t;
	typedef logic [`APU_VOL_W-1:0] volume_t;
	typedef logic [1:0] duty_t;

	// Length counter
	typedef logic [7:0] length_t;
	typedef logic [4:0] length_idx_t;

	// Sweep shift and divider period
	typedef logic [2:0] shift_t;

endpackage

`default_nettype wire

/* pulse_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface pulse_ctrl_if;
	import apu_pkg::*;

	// Decoded register fields
	duty_t duty;
	logic halt_loop;
	logic const_vol;
	volume_t vol;
	logic sweep_en;
	shift_t sweep_period;
	logic sweep_neg;
	shift_t sweep_shift;
	period_t period;
	length_idx_t lc_index;

	// Write events, one cycle after the write
	logic wr_sweep;
	logic wr_hi;

	// Period writeback from the sweep
	logic period_update;
	period_t new_period;

	modport regs (
		output duty, halt_loop, const_vol, vol, sweep_en, sweep_period, sweep_neg,
		output sweep_shift, period, lc_index, wr_sweep, wr_hi,
		input period_update, new_period
	);

	modport sweep (
		input sweep_en, sweep_period, sweep_neg, sweep_shift, period, wr_sweep,
		output period_update, new_period
	);

	modport env (input halt_loop, const_vol, vol, wr_hi);

	modport lc (input halt_loop, lc_index, wr_hi);

	modport seq (input duty, period, wr_hi);

endinterface

`default_nettype wire

/* pulse_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module pulse_regs (
	input logic timer_clk,
	input logic n_reset,
	input logic wr,
	input apu_pkg::reg_addr_t addr,
	input apu_pkg::reg_data_t wdata,
	pulse_ctrl_if.regs ctrl
);
	import apu_pkg::*;

	reg_data_t reg_ctrl;
	reg_data_t reg_sweep;
	length_idx_t lc_index;
	period_t period;
	logic wr_sweep;
	logic wr_hi;

	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset) begin
			reg_ctrl <= '0;
			reg_sweep <= '0;
			lc_index <= '0;
			wr_sweep <= 1'b0;
			wr_hi <= 1'b0;
		end else begin
			wr_sweep <= wr && addr == 2'd1;
			wr_hi <= wr && addr == 2'd3;
			if (wr && addr == 2'd0)
				reg_ctrl <= wdata;
			if (wr && addr == 2'd1)
				reg_sweep <= wdata;
			if (wr && addr == 2'd3)
				lc_index <= wdata[7:3];
		end
	end

	// Live period, a CPU write beats a sweep update
	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset)
			period <= '0;
		else if (wr && addr == 2'd2)
			period[7:0] <= wdata;
		else if (wr && addr == 2'd3)
			period[10:8] <= wdata[2:0];
		else if (ctrl.period_update)
			period <= ctrl.new_period;
	end

	assign ctrl.duty = reg_ctrl[7:6];
	assign ctrl.halt_loop = reg_ctrl[5];
	assign ctrl.const_vol = reg_ctrl[4];
	assign ctrl.vol = reg_ctrl[3:0];
	assign ctrl.sweep_en = reg_sweep[7];
	assign ctrl.sweep_period = reg_sweep[6:4];
	assign ctrl.sweep_neg = reg_sweep[3];
	assign ctrl.sweep_shift = reg_sweep[2:0];
	assign ctrl.period = period;
	assign ctrl.lc_index = lc_index;
	assign ctrl.wr_sweep = wr_sweep;
	assign ctrl.wr_hi = wr_hi;

	// On a clash the written half wins and the sweep result is dropped whole
	a_write_wins: assert property (@(posedge timer_clk) disable iff (!n_reset)
		(wr && addr[1] && ctrl.period_update) |=> ctrl.period == ($past(addr[0]) ?
			{$past(wdata[2:0]), $past(ctrl.period[7:0])} :
			{$past(ctrl.period[10:8]), $past(wdata)}));

endmodule

`default_nettype wire

/* apu_envelope.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_envelope (
	input logic timer_clk,
	input logic n_reset,
	input logic qframe,
	pulse_ctrl_if.env ctrl,
	output apu_pkg::volume_t volume
);
	import apu_pkg::*;

	logic start;
	volume_t divider;
	volume_t decay;

	// Set by a register 3 write, consumed by the next quarter frame
	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset)
			start <= 1'b0;
		else if (ctrl.wr_hi)
			start <= 1'b1;
		else if (qframe)
			start <= 1'b0;
	end

	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset) begin
			divider <= '0;
			decay <= '0;
		end else if (qframe) begin
			if (start) begin
				decay <= '1;
				divider <= ctrl.vol;
			end else if (divider == '0) begin
				divider <= ctrl.vol;
				if (decay != '0)
					decay <= decay - 1'b1;
				else if (ctrl.halt_loop)
					decay <= '1;
			end else begin
				divider <= divider - 1'b1;
			end
		end
	end

	assign volume = ctrl.const_vol ? ctrl.vol : decay;

endmodule

`default_nettype wire

/* apu_sweep.sv */
`timescale 1ns/1ps
`default_nettype none

`include "apu_cfg.svh"

module apu_sweep #(
	parameter bit sweep_ones_complement = 1'b1
) (
	input logic timer_clk,
	input logic n_reset,
	input logic hframe,
	pulse_ctrl_if.sweep ctrl,
	output logic mute
);
	import apu_pkg::*;

	shift_t divider;
	period_t shifted;
	logic [`APU_PERIOD_W:0] borrow;
	logic [`APU_PERIOD_W:0] target;
	logic overflow;

	assign shifted = ctrl.period >> ctrl.sweep_shift;

	// Extra borrow on negate for the first channel's adder
	assign borrow = {{`APU_PERIOD_W{1'b0}}, sweep_ones_complement};

	always_comb begin
		if (ctrl.sweep_neg)
			target = {1'b0, ctrl.period} - {1'b0, shifted} - borrow;
		else
			target = {1'b0, ctrl.period} + {1'b0, shifted};
	end

	assign overflow = !ctrl.sweep_neg && target[`APU_PERIOD_W];

	// Muting applies even with the sweep disabled
	assign mute = (ctrl.period < period_t'(`APU_MIN_PERIOD)) || overflow;

	assign ctrl.new_period = target[`APU_PERIOD_W-1:0];
	assign ctrl.period_update = hframe && divider == '0 && ctrl.sweep_en &&
		ctrl.sweep_shift != '0 && !mute;

	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset)
			divider <= '0;
		else if (ctrl.wr_sweep)
			divider <= ctrl.sweep_period;
		else if (hframe) begin
			if (divider == '0)
				divider <= ctrl.sweep_period;
			else
				divider <= divider - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* apu_length_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_length_counter (
	input logic timer_clk,
	input logic n_reset,
	input logic hframe,
	input logic en,
	pulse_ctrl_if.lc ctrl,
	output logic active
);
	import apu_pkg::*;

	length_t count;
	length_t load_value;

	// Length load table
	always_comb begin
		case (ctrl.lc_index)
			5'd0: load_value = 8'd10;
			5'd1: load_value = 8'd254;
			5'd2: load_value = 8'd20;
			5'd3: load_value = 8'd2;
			5'd4: load_value = 8'd40;
			5'd5: load_value = 8'd4;
			5'd6: load_value = 8'd80;
			5'd7: load_value = 8'd6;
			5'd8: load_value = 8'd160;
			5'd9: load_value = 8'd8;
			5'd10: load_value = 8'd60;
			5'd11: load_value = 8'd10;
			5'd12: load_value = 8'd14;
			5'd13: load_value = 8'd12;
			5'd14: load_value = 8'd26;
			5'd15: load_value = 8'd14;
			5'd16: load_value = 8'd12;
			5'd17: load_value = 8'd16;
			5'd18: load_value = 8'd24;
			5'd19: load_value = 8'd18;
			5'd20: load_value = 8'd48;
			5'd21: load_value = 8'd20;
			5'd22: load_value = 8'd96;
			5'd23: load_value = 8'd22;
			5'd24: load_value = 8'd192;
			5'd25: load_value = 8'd24;
			5'd26: load_value = 8'd72;
			5'd27: load_value = 8'd26;
			5'd28: load_value = 8'd16;
			5'd29: load_value = 8'd28;
			5'd30: load_value = 8'd32;
			default: load_value = 8'd30;
		endcase
	end

	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset)
			count <= '0;
		else if (!en)
			count <= '0;
		else if (ctrl.wr_hi)
			count <= load_value;
		else if (hframe && !ctrl.halt_loop && count != '0)
			count <= count - 1'b1;
	end

	assign active = count != '0;

	// Count only leaves zero through a load with the channel enabled
	a_no_load_disabled: assert property (@(posedge timer_clk) disable iff (!n_reset)
		$rose(active) |-> $past(ctrl.wr_hi && en));

endmodule

`default_nettype wire

/* pulse_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module pulse_sequencer (
	input logic timer_clk,
	input logic n_reset,
	input logic apu_tick,
	input apu_pkg::volume_t volume,
	input logic mute,
	input logic active,
	pulse_ctrl_if.seq ctrl,
	output apu_pkg::volume_t sample
);
	import apu_pkg::*;

	period_t timer;
	logic [2:0] step;
	logic duty_high;
	logic step_clk;

	assign step_clk = apu_tick && timer == '0;

	// Period timer
	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset)
			timer <= '0;
		else if (step_clk)
			timer <= ctrl.period;
		else if (apu_tick)
			timer <= timer - 1'b1;
	end

	// Step counter runs downwards, register 3 write restarts it
	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset)
			step <= '0;
		else if (ctrl.wr_hi)
			step <= '0;
		else if (step_clk)
			step <= step - 1'b1;
	end

	// High steps: 1, 2, 4 or 6 of 8
	always_comb begin
		case (ctrl.duty)
			2'd0: duty_high = step == 3'b111;
			2'd1: duty_high = step[2:1] == 2'b11;
			2'd2: duty_high = step[2];
			default: duty_high = step[2:1] != 2'b11;
		endcase
	end

	always_ff @(posedge timer_clk, negedge n_reset) begin
		if (!n_reset)
			sample <= '0;
		else if (active && duty_high && !mute)
			sample <= volume;
		else
			sample <= '0;
	end

endmodule

`default_nettype wire

/* apu_pulse.sv */
`timescale 1ns/1ps
`default_nettype none

module apu_pulse #(
	parameter bit sweep_ones_complement = 1'b1
) (
	input logic timer_clk,
	input logic n_reset,
	input logic wr,
	input apu_pkg::reg_addr_t addr,
	input apu_pkg::reg_data_t wdata,
	input logic apu_tick,
	input logic qframe,
	input logic hframe,
	input logic en,
	output logic active,
	output apu_pkg::volume_t sample
);
	import apu_pkg::*;

	volume_t volume;
	logic mute;

	pulse_ctrl_if ctrl_if ();

	pulse_regs i_pulse_regs (
		.timer_clk(timer_clk),
		.n_reset(n_reset),
		.wr(wr),
		.addr(addr),
		.wdata(wdata),
		.ctrl(ctrl_if.regs)
	);

	apu_envelope i_apu_envelope (
		.timer_clk(timer_clk),
		.n_reset(n_reset),
		.qframe(qframe),
		.ctrl(ctrl_if.env),
		.volume(volume)
	);

	apu_sweep #(
		.sweep_ones_complement(sweep_ones_complement)
	) i_apu_sweep (
		.timer_clk(timer_clk),
		.n_reset(n_reset),
		.hframe(hframe),
		.ctrl(ctrl_if.sweep),
		.mute(mute)
	);

	apu_length_counter i_apu_length_counter (
		.timer_clk(timer_clk),
		.n_reset(n_reset),
		.hframe(hframe),
		.en(en),
		.ctrl(ctrl_if.lc),
		.active(active)
	);

	pulse_sequencer i_pulse_sequencer (
		.timer_clk(timer_clk),
		.n_reset(n_reset),
		.apu_tick(apu_tick),
		.volume(volume),
		.mute(mute),
		.active(active),
		.ctrl(ctrl_if.seq),
		.sample(sample)
	);

endmodule

`default_nettype wire

/* tb_apu_pulse.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_apu_pulse;
	import apu_pkg::*;

	localparam int cycle_limit = 20000;
	localparam int duty_steps [4] = '{1, 2, 4, 6};
	localparam volume_t exp_level = 4'd9;

	logic timer_clk;
	logic n_reset;
	logic wr;
	reg_addr_t addr;
	reg_data_t wdata;
	logic apu_tick;
	logic qframe;
	logic hframe;
	logic en;
	logic active;
	volume_t sample;
	logic [15:0] lfsr;
	int cycle_count;
	logic hi_written;
	logic level_check;
	int high;
	int peak;
	int run;

	apu_pulse i_apu_pulse (.*);

	initial begin
		timer_clk = 1'b0;
		forever #20 timer_clk = ~timer_clk;
	end

	// Hung run guard
	always @(posedge timer_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Run did not finish within %0d cycles", cycle_limit);
			$display("sim failed");
			$fatal(1);
		end
	end

	task automatic report_mismatch(input string name, input int got, input int expected);
		$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		assert (got == expected)
		else report_mismatch(name, got, expected);
	endtask

	task automatic next_cycle();
		@(posedge timer_clk);
		#2;
	endtask

	task automatic write_reg(input int index, input int data);
		wr = 1'b1;
		addr = reg_addr_t'(index);
		wdata = reg_data_t'(data);
		if (index == 3)
			hi_written = 1'b1;
		next_cycle();
		wr = 1'b0;
	endtask

	// Gap of 1 to 8 cycles from a Fibonacci LFSR, taps 16 14 13 11
	task automatic frame_strobe(input logic half);
		int gap;
		logic feedback;
		gap = 0;
		repeat (3) begin
			feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], feedback};
			gap = gap * 2 + int'(feedback);
		end
		repeat (gap + 1)
			next_cycle();
		hframe = half;
		qframe = !half;
		next_cycle();
		hframe = 1'b0;
		qframe = 1'b0;
	endtask

	task automatic count_levels(input int cycles);
		high = 0;
		peak = 0;
		repeat (cycles) begin
			next_cycle();
			if (sample != '0)
				high++;
			if (int'(sample) > peak)
				peak = int'(sample);
		end
	endtask

	// Length of the next complete nonzero run
	task automatic measure_high_run();
		run = 0;
		while (sample != '0)
			next_cycle();
		while (sample == '0)
			next_cycle();
		while (sample != '0) begin
			run++;
			next_cycle();
		end
	endtask

	a_quiet_before_start: assert property (@(posedge timer_clk) disable iff (!n_reset)
		!hi_written |-> !active && sample == '0)
		else report_mismatch("active_sample", int'({$sampled(active), $sampled(sample)}), 0);

	a_silent_when_idle: assert property (@(posedge timer_clk) disable iff (!n_reset)
		!active |=> sample == '0)
		else report_mismatch("sample", int'($sampled(sample)), 0);

	a_sample_level: assert property (@(posedge timer_clk) disable iff (!n_reset)
		level_check && sample != '0 |-> sample == exp_level)
		else report_mismatch("sample", int'($sampled(sample)), int'(exp_level));

	initial begin
		n_reset = 1'b0;
		wr = 1'b0;
		addr = '0;
		wdata = '0;
		apu_tick = 1'b0;
		qframe = 1'b0;
		hframe = 1'b0;
		en = 1'b0;
		lfsr = 16'd52547;
		cycle_count = 0;
		hi_written = 1'b0;
		level_check = 1'b0;
		repeat (8) @(posedge timer_clk);
		#2;
		n_reset = 1'b1;
		en = 1'b1;
		apu_tick = 1'b1;

		// No sound until register 3 is written
		write_reg(0, 'hB9);
		write_reg(1, 'h00);
		write_reg(2, 20);
		frame_strobe(1'b0);
		frame_strobe(1'b1);
		check_value("active", int'(active), 0);
		check_value("sample", int'(sample), 0);

		// Duty 2 then duty 0, period 20
		write_reg(3, 'h08);
		level_check = 1'b1;
		repeat (200) next_cycle();
		count_levels(8 * 21);
		check_value("high cycles", high, duty_steps[2] * 21);
		write_reg(0, 'h39);
		repeat (200) next_cycle();
		count_levels(8 * 21);
		check_value("high cycles", high, duty_steps[0] * 21);

		// Index 3 loads 2
		write_reg(0, 'h99);
		write_reg(3, 'h18);
		frame_strobe(1'b1);
		check_value("active", int'(active), 1);
		frame_strobe(1'b1);
		check_value("active", int'(active), 0);
		write_reg(0, 'hB9);
		write_reg(3, 'h18);
		repeat (10) frame_strobe(1'b1);
		check_value("active", int'(active), 1);
		en = 1'b0;
		next_cycle();
		check_value("active", int'(active), 0);
		en = 1'b1;

		// Envelope decay, one level per quarter frame
		level_check = 1'b0;
		write_reg(0, 'h80);
		write_reg(3, 'h08);
		for (int k = 1; k <= 17; k++) begin
			frame_strobe(1'b0);
			count_levels(8 * 21);
			check_value("envelope peak", peak, (k >= 16) ? 0 : 16 - k);
		end
		write_reg(0, 'hA0);
		frame_strobe(1'b0);
		count_levels(8 * 21);
		check_value("envelope peak", peak, 15);

		// Sweep from 0x100 with shift 2
		write_reg(0, 'hB9);
		write_reg(1, 'h82);
		write_reg(2, 'h00);
		write_reg(3, 'h09);
		level_check = 1'b1;
		frame_strobe(1'b1);
		repeat (300) next_cycle();
		measure_high_run();
		check_value("high run", run, duty_steps[2] * ('h140 + 1));
		write_reg(1, 'h8A);
		write_reg(2, 'h00);
		write_reg(3, 'h09);
		frame_strobe(1'b1);
		repeat (300) next_cycle();
		measure_high_run();
		check_value("high run", run, duty_steps[2] * ('hBF + 1));

		// Short period, then a target past 0x7FF
		write_reg(1, 'h00);
		write_reg(2, 7);
		write_reg(3, 'h08);
		count_levels(200);
		check_value("high cycles", high, 0);
		check_value("active", int'(active), 1);
		write_reg(1, 'h01);
		write_reg(2, 'h00);
		write_reg(3, 'h0E);
		count_levels(1800);
		check_value("high cycles", high, 0);
		check_value("active", int'(active), 1);

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
apu_pkg.sv
pulse_ctrl_if.sv
pulse_regs.sv
apu_envelope.sv
apu_sweep.sv
apu_length_counter.sv
pulse_sequencer.sv
apu_pulse.sv
tb_apu_pulse.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pulse channel testbench, exit status gives the result
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert --top-module tb_apu_pulse -f build.f -o tb_apu_pulse &&
	./obj_dir/tb_apu_pulse ||
	exit 1
